// File: hdl/rvIsaPkg.sv
`default_nettype none

package rvIsaPkg;

    // Major opcodes in instr[6:0]
    localparam logic [6:0] OpLoad   = 7'b0000011;
    localparam logic [6:0] OpStore  = 7'b0100011;
    localparam logic [6:0] OpBranch = 7'b1100011;
    localparam logic [6:0] OpJal    = 7'b1101111;
    localparam logic [6:0] OpJalr   = 7'b1100111;
    localparam logic [6:0] OpOpImm  = 7'b0010011;
    localparam logic [6:0] OpOp     = 7'b0110011;
    localparam logic [6:0] OpLui    = 7'b0110111;

    localparam logic [2:0] Funct3Beq  = 3'b000;
    localparam logic [2:0] Funct3Bne  = 3'b001;
    localparam logic [2:0] Funct3Blt  = 3'b100;
    localparam logic [2:0] Funct3Bge  = 3'b101;
    localparam logic [2:0] Funct3Bltu = 3'b110;
    localparam logic [2:0] Funct3Bgeu = 3'b111;

    localparam logic [2:0] Funct3AddSub = 3'b000; // Bit 30 picks SUB on register-register ops
    localparam logic [2:0] Funct3Sll    = 3'b001;
    localparam logic [2:0] Funct3Slt    = 3'b010;
    localparam logic [2:0] Funct3Sltu   = 3'b011;
    localparam logic [2:0] Funct3Xor    = 3'b100;
    localparam logic [2:0] Funct3Srl    = 3'b101; // Bit 30 picks the arithmetic shift
    localparam logic [2:0] Funct3Or     = 3'b110;
    localparam logic [2:0] Funct3And    = 3'b111;

    localparam logic [2:0] ImmI = 3'd0;
    localparam logic [2:0] ImmS = 3'd1;
    localparam logic [2:0] ImmB = 3'd2;
    localparam logic [2:0] ImmU = 3'd3;
    localparam logic [2:0] ImmJ = 3'd4;

endpackage

`default_nettype wire

// File: hdl/pipeCtrlPkg.sv
`default_nettype none

package pipeCtrlPkg;

    localparam int Xlen = 32;
    localparam int DefaultNumRegs = 32; // RV32E builds pass 16 instead

    localparam logic [3:0] AluAdd   = 4'd0;
    localparam logic [3:0] AluSub   = 4'd1;
    localparam logic [3:0] AluAnd   = 4'd2;
    localparam logic [3:0] AluOr    = 4'd3;
    localparam logic [3:0] AluXor   = 4'd4;
    localparam logic [3:0] AluSlt   = 4'd5;
    localparam logic [3:0] AluSltu  = 4'd6;
    localparam logic [3:0] AluSll   = 4'd7;
    localparam logic [3:0] AluSrl   = 4'd8;
    localparam logic [3:0] AluSra   = 4'd9;
    localparam logic [3:0] AluPassB = 4'd10;

    localparam logic [1:0] ResAlu     = 2'd0;
    localparam logic [1:0] ResMem     = 2'd1;
    localparam logic [1:0] ResPcPlus4 = 2'd2;

endpackage

`default_nettype wire

// File: hdl/controlDecoder.sv
`timescale 1ns/100ps
`default_nettype none

module controlDecoder (
    input  logic [31:0] instr,
    output logic        memRead,
    output logic        regWrite,
    output logic [1:0]  resultSrc,
    output logic        memWrite,
    output logic        jump,
    output logic        branch,
    output logic [3:0]  aluControl,
    output logic        aluSrc,
    output logic [2:0]  immSrc
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       funct7b5;
    logic       isRegOp;
    logic [3:0] functAlu;

    assign opcode   = instr[6:0];
    assign funct3   = instr[14:12];
    assign funct7b5 = instr[30];
    assign isRegOp  = (opcode == rvIsaPkg::OpOp);

    always_comb begin
        functAlu = pipeCtrlPkg::AluAdd;
        case (funct3)
            rvIsaPkg::Funct3AddSub: begin
                functAlu = (isRegOp && funct7b5) ? pipeCtrlPkg::AluSub : pipeCtrlPkg::AluAdd;
            end
            rvIsaPkg::Funct3Sll:  functAlu = pipeCtrlPkg::AluSll;
            rvIsaPkg::Funct3Slt:  functAlu = pipeCtrlPkg::AluSlt;
            rvIsaPkg::Funct3Sltu: functAlu = pipeCtrlPkg::AluSltu;
            rvIsaPkg::Funct3Xor:  functAlu = pipeCtrlPkg::AluXor;
            rvIsaPkg::Funct3Srl:  functAlu = funct7b5 ? pipeCtrlPkg::AluSra : pipeCtrlPkg::AluSrl;
            rvIsaPkg::Funct3Or:   functAlu = pipeCtrlPkg::AluOr;
            rvIsaPkg::Funct3And:  functAlu = pipeCtrlPkg::AluAnd;
            default:              functAlu = pipeCtrlPkg::AluAdd;
        endcase
    end

    always_comb begin
        memRead    = 1'b0;
        regWrite   = 1'b0;
        resultSrc  = pipeCtrlPkg::ResAlu;
        memWrite   = 1'b0;
        jump       = 1'b0;
        branch     = 1'b0;
        aluControl = pipeCtrlPkg::AluAdd;
        aluSrc     = 1'b0;
        immSrc     = rvIsaPkg::ImmI;
        case (opcode)
            rvIsaPkg::OpLoad: begin
                memRead   = 1'b1;
                regWrite  = 1'b1;
                resultSrc = pipeCtrlPkg::ResMem;
                aluSrc    = 1'b1;
            end
            rvIsaPkg::OpStore: begin
                memWrite = 1'b1;
                aluSrc   = 1'b1;
                immSrc   = rvIsaPkg::ImmS;
            end
            rvIsaPkg::OpBranch: begin
                branch     = 1'b1;
                aluControl = pipeCtrlPkg::AluSub;
                immSrc     = rvIsaPkg::ImmB;
            end
            rvIsaPkg::OpJal: begin
                jump      = 1'b1;
                regWrite  = 1'b1;
                resultSrc = pipeCtrlPkg::ResPcPlus4;
                immSrc    = rvIsaPkg::ImmJ;
            end
            rvIsaPkg::OpJalr: begin
                jump      = 1'b1;
                regWrite  = 1'b1;
                resultSrc = pipeCtrlPkg::ResPcPlus4;
                aluSrc    = 1'b1; // Execute uses this to tell JALR from JAL
            end
            rvIsaPkg::OpOpImm: begin
                regWrite   = 1'b1;
                aluControl = functAlu;
                aluSrc     = 1'b1;
            end
            rvIsaPkg::OpOp: begin
                regWrite   = 1'b1;
                aluControl = functAlu;
            end
            rvIsaPkg::OpLui: begin
                regWrite   = 1'b1;
                aluControl = pipeCtrlPkg::AluPassB;
                aluSrc     = 1'b1;
                immSrc     = rvIsaPkg::ImmU;
            end
            default: ; // Unknown opcodes leave every control inactive
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/regFile.sv
`timescale 1ns/100ps
`default_nettype none

module regFile #(
    parameter int NumRegs = pipeCtrlPkg::DefaultNumRegs
) (
    input  logic                         clk,
    input  logic                         rstN,
    input  logic [4:0]                   rs1,
    input  logic [4:0]                   rs2,
    input  logic                         wbEn,
    input  logic [4:0]                   wbAddr,
    input  logic [pipeCtrlPkg::Xlen-1:0] wbData,
    output logic [pipeCtrlPkg::Xlen-1:0] rd1,
    output logic [pipeCtrlPkg::Xlen-1:0] rd2
);

    localparam int AddrBits = $clog2(NumRegs);

    logic [pipeCtrlPkg::Xlen-1:0] regs [NumRegs];
    logic                         wbValid;

    // Writes to x0 or past the last register are dropped
    assign wbValid = wbEn && (wbAddr != 5'd0) && (int'(wbAddr) < NumRegs);

    function automatic logic [pipeCtrlPkg::Xlen-1:0] readPort(input logic [4:0] addr);
        logic [pipeCtrlPkg::Xlen-1:0] value;
        if (addr == 5'd0 || int'(addr) >= NumRegs) begin
            value = '0;
        end else if (wbValid && addr == wbAddr) begin
            value = wbData; // Same-cycle write reaches decode directly
        end else begin
            value = regs[addr[AddrBits-1:0]];
        end
        return value;
    endfunction

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < NumRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (wbValid) begin
            regs[wbAddr[AddrBits-1:0]] <= wbData;
        end
    end

    always_comb begin
        rd1 = readPort(rs1);
        rd2 = readPort(rs2);
    end

endmodule

`default_nettype wire

// File: hdl/immExtend.sv
`timescale 1ns/100ps
`default_nettype none

module immExtend (
    input  logic [31:0]                  instr,
    input  logic [2:0]                   immSrc,
    output logic [pipeCtrlPkg::Xlen-1:0] extImm
);

    localparam int Xlen = pipeCtrlPkg::Xlen;

    logic sign;

    assign sign = instr[31];

    always_comb begin
        case (immSrc)
            rvIsaPkg::ImmI: extImm = {{(Xlen-12){sign}}, instr[31:20]};
            rvIsaPkg::ImmS: extImm = {{(Xlen-12){sign}}, instr[31:25], instr[11:7]};
            rvIsaPkg::ImmB: begin
                extImm = {{(Xlen-13){sign}}, sign, instr[7], instr[30:25], instr[11:8], 1'b0};
            end
            rvIsaPkg::ImmU: extImm = {{(Xlen-32){sign}}, instr[31:12], 12'b0};
            rvIsaPkg::ImmJ: begin
                // J offset bits are scattered over the upper instruction half
                extImm = {{(Xlen-21){sign}}, sign, instr[19:12], instr[20], instr[30:21], 1'b0};
            end
            default: extImm = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/decodeExecuteReg.sv
`timescale 1ns/100ps
`default_nettype none

module decodeExecuteReg (
    input  logic                         clk,
    input  logic                         rstN,
    input  logic                         flush,
    input  logic                         memReadD,
    output logic                         memReadE,
    input  logic                         regWriteD,
    output logic                         regWriteE,
    input  logic [1:0]                   resultSrcD,
    output logic [1:0]                   resultSrcE,
    input  logic                         memWriteD,
    output logic                         memWriteE,
    input  logic                         jumpD,
    output logic                         jumpE,
    input  logic                         branchD,
    output logic                         branchE,
    input  logic [3:0]                   aluControlD,
    output logic [3:0]                   aluControlE,
    input  logic                         aluSrcD,
    output logic                         aluSrcE,
    input  logic [2:0]                   modeAddrD,
    output logic [2:0]                   modeAddrE,
    input  logic [pipeCtrlPkg::Xlen-1:0] rd1D,
    output logic [pipeCtrlPkg::Xlen-1:0] rd1E,
    input  logic [pipeCtrlPkg::Xlen-1:0] rd2D,
    output logic [pipeCtrlPkg::Xlen-1:0] rd2E,
    input  logic [pipeCtrlPkg::Xlen-1:0] pcD,
    output logic [pipeCtrlPkg::Xlen-1:0] pcE,
    input  logic [4:0]                   rdD,
    output logic [4:0]                   rdE,
    input  logic [pipeCtrlPkg::Xlen-1:0] extImmD,
    output logic [pipeCtrlPkg::Xlen-1:0] extImmE,
    input  logic [pipeCtrlPkg::Xlen-1:0] pcPlus4D,
    output logic [pipeCtrlPkg::Xlen-1:0] pcPlus4E
);

    // 15 control bits, rd and five data words
    localparam int Width = 5 * pipeCtrlPkg::Xlen + 20;

    logic [Width-1:0] stageD;
    logic [Width-1:0] stageE;

    assign stageD = {memReadD, regWriteD, resultSrcD, memWriteD, jumpD, branchD, aluControlD,
                     aluSrcD, modeAddrD, rd1D, rd2D, pcD, rdD, extImmD, pcPlus4D};

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            stageE <= '0;
        end else if (flush) begin
            stageE <= '0; // The wrong-path instruction becomes a bubble
        end else begin
            stageE <= stageD;
        end
    end

    assign {memReadE, regWriteE, resultSrcE, memWriteE, jumpE, branchE, aluControlE,
            aluSrcE, modeAddrE, rd1E, rd2E, pcE, rdE, extImmE, pcPlus4E} = stageE;

endmodule

`default_nettype wire

// File: hdl/executeUnit.sv
`timescale 1ns/100ps
`default_nettype none

module executeUnit (
    input  logic                         jumpE,
    input  logic                         branchE,
    input  logic [3:0]                   aluControlE,
    input  logic                         aluSrcE,
    input  logic [2:0]                   modeAddrE,
    input  logic [pipeCtrlPkg::Xlen-1:0] rd1E,
    input  logic [pipeCtrlPkg::Xlen-1:0] rd2E,
    input  logic [pipeCtrlPkg::Xlen-1:0] pcE,
    input  logic [pipeCtrlPkg::Xlen-1:0] extImmE,
    output logic [pipeCtrlPkg::Xlen-1:0] aluResultE,
    output logic [pipeCtrlPkg::Xlen-1:0] writeDataE,
    output logic                         redirect,
    output logic [pipeCtrlPkg::Xlen-1:0] redirectTarget
);

    localparam int Xlen = pipeCtrlPkg::Xlen;
    localparam int ShiftBits = $clog2(Xlen);

    logic [Xlen-1:0]      srcB;
    logic [Xlen-1:0]      aluSum;
    logic [ShiftBits-1:0] shamt;
    logic                 branchTaken;

    assign srcB   = aluSrcE ? extImmE : rd2E;
    assign aluSum = rd1E + srcB;
    assign shamt  = srcB[ShiftBits-1:0];

    always_comb begin
        case (aluControlE)
            pipeCtrlPkg::AluAdd:   aluResultE = aluSum;
            pipeCtrlPkg::AluSub:   aluResultE = rd1E - srcB;
            pipeCtrlPkg::AluAnd:   aluResultE = rd1E & srcB;
            pipeCtrlPkg::AluOr:    aluResultE = rd1E | srcB;
            pipeCtrlPkg::AluXor:   aluResultE = rd1E ^ srcB;
            pipeCtrlPkg::AluSlt:   aluResultE = {{(Xlen-1){1'b0}}, $signed(rd1E) < $signed(srcB)};
            pipeCtrlPkg::AluSltu:  aluResultE = {{(Xlen-1){1'b0}}, rd1E < srcB};
            pipeCtrlPkg::AluSll:   aluResultE = rd1E << shamt;
            pipeCtrlPkg::AluSrl:   aluResultE = rd1E >> shamt;
            pipeCtrlPkg::AluSra:   aluResultE = $unsigned($signed(rd1E) >>> shamt);
            pipeCtrlPkg::AluPassB: aluResultE = srcB;
            default:               aluResultE = '0;
        endcase
    end

    // Branches always compare the two register operands
    always_comb begin
        case (modeAddrE)
            rvIsaPkg::Funct3Beq:  branchTaken = (rd1E == rd2E);
            rvIsaPkg::Funct3Bne:  branchTaken = (rd1E != rd2E);
            rvIsaPkg::Funct3Blt:  branchTaken = ($signed(rd1E) < $signed(rd2E));
            rvIsaPkg::Funct3Bge:  branchTaken = ($signed(rd1E) >= $signed(rd2E));
            rvIsaPkg::Funct3Bltu: branchTaken = (rd1E < rd2E);
            rvIsaPkg::Funct3Bgeu: branchTaken = (rd1E >= rd2E);
            default:              branchTaken = 1'b0;
        endcase
    end

    assign redirect = jumpE || (branchE && branchTaken);

    // JALR targets come from rs1 plus the immediate, everything else is PC relative
    assign redirectTarget = (jumpE && aluSrcE) ? {aluSum[Xlen-1:1], 1'b0} : pcE + extImmE;

    assign writeDataE = rd2E;

endmodule

`default_nettype wire

// File: hdl/decodeExecuteSlice.sv
`timescale 1ns/100ps
`default_nettype none

module decodeExecuteSlice #(
    parameter int NumRegs = pipeCtrlPkg::DefaultNumRegs
) (
    input  logic                         clk,
    input  logic                         rstN,
    input  logic [31:0]                  instr,
    input  logic [pipeCtrlPkg::Xlen-1:0] pc,
    input  logic                         wbEn,
    input  logic [4:0]                   wbAddr,
    input  logic [pipeCtrlPkg::Xlen-1:0] wbData,
    output logic                         memReadE,
    output logic                         memWriteE,
    output logic                         regWriteE,
    output logic [1:0]                   resultSrcE,
    output logic [2:0]                   modeAddrE,
    output logic [4:0]                   rdE,
    output logic [pipeCtrlPkg::Xlen-1:0] aluResultE,
    output logic [pipeCtrlPkg::Xlen-1:0] writeDataE,
    output logic [pipeCtrlPkg::Xlen-1:0] pcPlus4E,
    output logic                         redirect,
    output logic [pipeCtrlPkg::Xlen-1:0] redirectTarget
);

    localparam int Xlen = pipeCtrlPkg::Xlen;

    logic            memReadD;
    logic            regWriteD;
    logic            memWriteD;
    logic            jumpD;
    logic            branchD;
    logic            aluSrcD;
    logic [1:0]      resultSrcD;
    logic [3:0]      aluControlD;
    logic [2:0]      immSrcD;
    logic [Xlen-1:0] rd1D;
    logic [Xlen-1:0] rd2D;
    logic [Xlen-1:0] extImmD;
    logic [Xlen-1:0] pcPlus4D;

    logic            jumpE;
    logic            branchE;
    logic            aluSrcE;
    logic [3:0]      aluControlE;
    logic [Xlen-1:0] rd1E;
    logic [Xlen-1:0] rd2E;
    logic [Xlen-1:0] pcE;
    logic [Xlen-1:0] extImmE;

    assign pcPlus4D = pc + Xlen'(4);

    controlDecoder uControlDecoder (
        .instr(instr), .memRead(memReadD), .regWrite(regWriteD), .resultSrc(resultSrcD),
        .memWrite(memWriteD), .jump(jumpD), .branch(branchD), .aluControl(aluControlD),
        .aluSrc(aluSrcD), .immSrc(immSrcD)
    );

    regFile #(.NumRegs(NumRegs)) uRegFile (
        .clk(clk), .rstN(rstN), .rs1(instr[19:15]), .rs2(instr[24:20]), .wbEn(wbEn),
        .wbAddr(wbAddr), .wbData(wbData), .rd1(rd1D), .rd2(rd2D)
    );

    immExtend uImmExtend (.instr(instr), .immSrc(immSrcD), .extImm(extImmD));

    // A redirect in execute squashes the instruction now in decode
    decodeExecuteReg uDecodeExecuteReg (
        .clk(clk), .rstN(rstN), .flush(redirect),
        .memReadD(memReadD), .memReadE(memReadE), .regWriteD(regWriteD), .regWriteE(regWriteE),
        .resultSrcD(resultSrcD), .resultSrcE(resultSrcE), .memWriteD(memWriteD),
        .memWriteE(memWriteE), .jumpD(jumpD), .jumpE(jumpE), .branchD(branchD),
        .branchE(branchE), .aluControlD(aluControlD), .aluControlE(aluControlE),
        .aluSrcD(aluSrcD), .aluSrcE(aluSrcE), .modeAddrD(instr[14:12]), .modeAddrE(modeAddrE),
        .rd1D(rd1D), .rd1E(rd1E), .rd2D(rd2D), .rd2E(rd2E), .pcD(pc), .pcE(pcE),
        .rdD(instr[11:7]), .rdE(rdE), .extImmD(extImmD), .extImmE(extImmE),
        .pcPlus4D(pcPlus4D), .pcPlus4E(pcPlus4E)
    );

    executeUnit uExecuteUnit (
        .jumpE(jumpE), .branchE(branchE), .aluControlE(aluControlE), .aluSrcE(aluSrcE),
        .modeAddrE(modeAddrE), .rd1E(rd1E), .rd2E(rd2E), .pcE(pcE), .extImmE(extImmE),
        .aluResultE(aluResultE), .writeDataE(writeDataE), .redirect(redirect),
        .redirectTarget(redirectTarget)
    );

endmodule

`default_nettype wire

// File: dv/sliceTb.sv
`timescale 1ns/100ps
`default_nettype none

module sliceTb;

    localparam int Xlen = pipeCtrlPkg::Xlen;
    localparam int EdgeTimeout = 100; // Polls of 0.1 ns, far longer than one 4 ns period
    localparam int MaxLines = 1000;

    logic            clk;
    logic            rstN;
    logic [31:0]     instr;
    logic [Xlen-1:0] pc;
    logic            wbEn;
    logic [4:0]      wbAddr;
    logic [Xlen-1:0] wbData;
    logic            memReadE;
    logic            memWriteE;
    logic            regWriteE;
    logic [1:0]      resultSrcE;
    logic [2:0]      modeAddrE;
    logic [4:0]      rdE;
    logic [Xlen-1:0] aluResultE;
    logic [Xlen-1:0] writeDataE;
    logic [Xlen-1:0] pcPlus4E;
    logic            redirect;
    logic [Xlen-1:0] redirectTarget;

    int      edgeCount;
    realtime lastEdge;
    logic    timedOut;
    int      passCount;
    int      failCount;
    int      testErrors;

    // Expectation of the instruction now sitting in execute
    logic          pendValid;
    logic [191:0]  pendName;
    logic [31:0]   pendExp [11];
    logic [31:0]   newExp [11];

    decodeExecuteSlice #(.NumRegs(pipeCtrlPkg::DefaultNumRegs)) uut (
        .clk(clk), .rstN(rstN), .instr(instr), .pc(pc), .wbEn(wbEn), .wbAddr(wbAddr),
        .wbData(wbData), .memReadE(memReadE), .memWriteE(memWriteE), .regWriteE(regWriteE),
        .resultSrcE(resultSrcE), .modeAddrE(modeAddrE), .rdE(rdE), .aluResultE(aluResultE),
        .writeDataE(writeDataE), .pcPlus4E(pcPlus4E), .redirect(redirect),
        .redirectTarget(redirectTarget)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    always @(posedge clk) begin
        edgeCount = edgeCount + 1;
        lastEdge = $realtime;
    end

    task automatic waitNextEdge();
        int target;
        int polls;
        target = edgeCount + 1;
        polls = 0;
        while (!timedOut && edgeCount < target && polls < EdgeTimeout) begin
            #0.1;
            polls++;
        end
        if (!timedOut && edgeCount < target) begin
            $display("Timeout: the clock stopped, no rising edge came");
            timedOut = 1'b1;
        end
    endtask

    task automatic compareField(input logic [191:0] name, input logic [127:0] field,
                                input logic [31:0] expected, input logic [31:0] actual);
        if (actual !== expected) begin
            $display("Mismatch %0s %0s expected %h actual %h", name, field, expected, actual);
            testErrors++;
        end
    endtask

    task automatic checkPending();
        testErrors = 0;
        compareField(pendName, "aluResultE", pendExp[0], aluResultE);
        compareField(pendName, "writeDataE", pendExp[1], writeDataE);
        compareField(pendName, "memReadE", pendExp[2], 32'(memReadE));
        compareField(pendName, "memWriteE", pendExp[3], 32'(memWriteE));
        compareField(pendName, "regWriteE", pendExp[4], 32'(regWriteE));
        compareField(pendName, "resultSrcE", pendExp[5], 32'(resultSrcE));
        compareField(pendName, "rdE", pendExp[6], 32'(rdE));
        compareField(pendName, "redirect", pendExp[7], 32'(redirect));
        if (pendExp[7] == 32'd1) begin
            compareField(pendName, "redirectTarget", pendExp[8], redirectTarget);
        end
        compareField(pendName, "pcPlus4E", pendExp[9], pcPlus4E);
        compareField(pendName, "modeAddrE", pendExp[10], 32'(modeAddrE));
        if (testErrors == 0) begin
            $display("PASS %0s", pendName);
            passCount++;
        end else begin
            $display("FAIL %0s with %0d wrong fields", pendName, testErrors);
            failCount++;
        end
        pendValid = 1'b0;
    endtask

    // One decode cycle: drive after the edge, then check the previous instruction
    task automatic runCycle(input logic [31:0] i, input logic [31:0] p, input logic we,
                            input logic [4:0] wa, input logic [31:0] wd);
        waitNextEdge();
        if (!timedOut) begin
            #(lastEdge + 0.5 - $realtime);
            instr = i;
            pc = p;
            wbEn = we;
            wbAddr = wa;
            wbData = wd;
            #(lastEdge + 3.0 - $realtime);
            if (pendValid) checkPending();
        end
    endtask

    initial begin
        int fd;
        int code;
        int lineCount;
        logic         done;
        logic [191:0] nameBuf;
        logic [7:0]   kindChar;
        logic [959:0] restLine;
        logic [31:0]  tInstr;
        logic [31:0]  tPc;
        logic [31:0]  wA;
        logic [31:0]  wD;
        logic         haveWrite;
        logic [4:0]   pwA;
        logic [31:0]  pwD;
        logic [191:0] pwName;

        rstN = 1'b0;
        instr = '0;
        pc = '0;
        wbEn = 1'b0;
        wbAddr = '0;
        wbData = '0;
        edgeCount = 0;
        lastEdge = 0.0;
        timedOut = 1'b0;
        passCount = 0;
        failCount = 0;
        pendValid = 1'b0;
        haveWrite = 1'b0;
        pwA = '0;
        pwD = '0;
        pwName = '0;

        repeat (8) waitNextEdge();
        #(lastEdge + 0.5 - $realtime);
        rstN = 1'b1;

        // Nothing has entered the pipeline yet, so every output reads zero
        #(lastEdge + 3.0 - $realtime);
        pendName = "resetState";
        for (int k = 0; k < 11; k++) begin
            pendExp[k] = '0;
        end
        checkPending();

        fd = $fopen("dv/sliceTests.txt", "r");
        if (fd == 0) begin
            $display("Could not open the test file dv/sliceTests.txt");
            failCount++;
        end else begin
            done = 1'b0;
            lineCount = 0;
            while (!done && !timedOut && lineCount < MaxLines) begin
                code = $fscanf(fd, "%s", nameBuf);
                if (code != 1) begin
                    done = 1'b1;
                end else if (nameBuf[7:0] == "#" && nameBuf[191:8] == '0) begin
                    code = $fgets(restLine, fd);
                end else begin
                    lineCount++;
                    code = $fscanf(fd, "%s", kindChar);
                    if (kindChar == "W") begin
                        code = $fscanf(fd, "%h %h", wA, wD);
                        if (haveWrite) begin
                            runCycle(32'h0, 32'h0, 1'b1, pwA, pwD);
                            $display("DONE %0s wrote x%0d = %h", pwName, pwA, pwD);
                        end
                        haveWrite = 1'b1;
                        pwA = wA[4:0];
                        pwD = wD;
                        pwName = nameBuf;
                    end else if (kindChar == "I" || kindChar == "B") begin
                        if (kindChar == "I") begin
                            code = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h %h",
                                           tInstr, tPc, newExp[0], newExp[1], newExp[2],
                                           newExp[3], newExp[4], newExp[5], newExp[6],
                                           newExp[7], newExp[8], newExp[9]);
                            newExp[10] = 32'(tInstr[14:12]); // funct3 travels as the mode
                        end else begin
                            code = $fscanf(fd, "%h %h", tInstr, tPc);
                            for (int k = 0; k < 11; k++) begin
                                newExp[k] = '0; // A flushed slot carries nothing
                            end
                        end
                        runCycle(tInstr, tPc, haveWrite, pwA, pwD);
                        if (haveWrite) begin
                            $display("DONE %0s wrote x%0d = %h", pwName, pwA, pwD);
                        end
                        haveWrite = 1'b0;
                        pendName = nameBuf;
                        pendExp = newExp;
                        pendValid = 1'b1;
                    end else begin
                        $display("Test %0s has an unknown kind in the test file", nameBuf);
                        failCount++;
                    end
                end
            end
            if (!done && !timedOut) begin
                $display("Test file did not end within %0d tests", MaxLines);
                failCount++;
            end
            $fclose(fd);
            if (haveWrite) begin
                runCycle(32'h0, 32'h0, 1'b1, pwA, pwD);
                $display("DONE %0s wrote x%0d = %h", pwName, pwA, pwD);
            end
            runCycle(32'h0, 32'h0, 1'b0, 5'd0, 32'h0); // Lets the last instruction be checked
        end

        $display("Tests passed: %0d, failed: %0d", passCount, failCount);
        if (failCount == 0 && !timedOut) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: dv/sliceTests.txt
# name W addr data | name B instr pc
# name I instr pc aluResult writeData memRead memWrite regWrite resultSrc rd redirect target pcPlus4
preX1 W 1 00000005
preX2 W 2 00000003
preX3 W 3 fffffff8
preX4 W 4 00001000
preX5 W 5 12345678
addR I 00208333 100 00000008 00000003 0 0 1 0 6 0 xxxxxxxx 104
subR I 402083b3 104 00000002 00000003 0 0 1 0 7 0 xxxxxxxx 108
sltR I 0011a433 108 00000001 00000005 0 0 1 0 8 0 xxxxxxxx 10c
sltuR I 0011b4b3 10c 00000000 00000005 0 0 1 0 9 0 xxxxxxxx 110
sraR I 4021d533 110 ffffffff 00000003 0 0 1 0 a 0 xxxxxxxx 114
xoriI I 0ff2c593 114 12345687 00000000 0 0 1 0 b 0 xxxxxxxx 118
luiU I abcde637 118 abcde000 00000000 0 0 1 0 c 0 xxxxxxxx 11c
loadW I 01022683 11c 00001010 00000000 1 0 1 1 d 0 xxxxxxxx 120
storeW I fe522e23 120 00000ffc 12345678 0 1 0 0 1c 0 xxxxxxxx 124
beqTaken I 00108863 124 00000000 00000005 0 0 0 0 10 1 00000134 128
flushBeq B 00208333 128
beqNot I 00208863 134 00000002 00000003 0 0 0 0 10 0 xxxxxxxx 138
bneTaken I 00209863 138 00000002 00000003 0 0 0 0 10 1 00000148 13c
flushBne B 0ff2c593 13c
bneNot I 00109863 148 00000000 00000005 0 0 0 0 10 0 xxxxxxxx 14c
bltTaken I 0011c863 14c fffffff3 00000005 0 0 0 0 10 1 0000015c 150
flushBlt B 00208333 150
bltuNeg I 0011e863 15c fffffff3 00000005 0 0 0 0 10 0 xxxxxxxx 160
bgeNeg I 0011d863 160 fffffff3 00000005 0 0 0 0 10 0 xxxxxxxx 164
bgeuTaken I 0011f863 164 fffffff3 00000005 0 0 0 0 10 1 00000174 168
flushBgeu B 00208333 168
bltNot I 0020c863 174 00000002 00000003 0 0 0 0 10 0 xxxxxxxx 178
bltuTaken I 00116863 178 fffffffe 00000005 0 0 0 0 10 1 00000188 17c
flushBltu B 00208333 17c
bgeTaken I 0020d863 188 00000002 00000003 0 0 0 0 10 1 00000198 18c
flushBge B 00208333 18c
bgeuNot I 00117863 198 fffffffe 00000005 0 0 0 0 10 0 xxxxxxxx 19c
jal I 020000ef 19c 00000000 00000000 0 0 1 2 1 1 000001bc 1a0
flushJal B 00208333 1a0
jalr I 007202e7 1bc 00001007 00000000 0 0 1 2 5 1 00001006 1c0
flushJalr B 00208333 1c0
zeroWrite W 0 deadbeef
readX0 I 00100733 200 00000005 00000005 0 0 1 0 e 0 xxxxxxxx 204
bypassX6 W 6 0000000a
bypassRead I 00130793 204 0000000b 00000005 0 0 1 0 f 0 xxxxxxxx 208
afterWrite I 00030813 208 0000000a 00000000 0 0 1 0 10 0 xxxxxxxx 20c

// File: verilog.f
hdl/rvIsaPkg.sv
hdl/pipeCtrlPkg.sv
hdl/controlDecoder.sv
hdl/regFile.sv
hdl/immExtend.sv
hdl/decodeExecuteReg.sv
hdl/executeUnit.sv
hdl/decodeExecuteSlice.sv
dv/sliceTb.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= sliceTb
FILELIST ?= verilog.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, fail on a reported failure"
	@echo "  clean  remove the build directory and the log"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Simulation FAILED" $(LOG); then echo "Test failed"; exit 1; fi
	@grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
